//--- include/rx_align_params.svh
`ifndef RX_ALIGN_PARAMS_SVH
`define RX_ALIGN_PARAMS_SVH

// Channel geometry
`define RXA_NUM_CHANNELS      2
`define RXA_BITS_PER_CHANNEL  80

// Strobe search words, 40 bits each
`define RXA_WORD_BITS         40
`define RXA_WORDS_PER_CHANNEL 2
`define RXA_WD_SEL_BITS       8  // Full field width of the word select

// Alignment FIFO, depth 8
`define RXA_FIFO_AD_WIDTH     3

// Counters
`define RXA_INTV_BITS         16
`define RXA_DLY_BITS          3

`endif

//--- rtl/rx_align_pkg.sv
`include "rx_align_params.svh"

package rx_align_pkg;

  ////////////////////////////////////////////////////////////
  // One channel word, seen two ways
  ////////////////////////////////////////////////////////////

  typedef union packed {
    logic [`RXA_BITS_PER_CHANNEL-1:0] flat;  // FIFO payload
    logic [`RXA_WORDS_PER_CHANNEL-1:0][`RXA_WORD_BITS-1:0] word;  // Strobe search words
  } chan_word_u;

  ////////////////////////////////////////////////////////////
  // Alignment controller states
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    st_idle       = 3'h0,
    st_online     = 3'h1,
    st_aligned    = 3'h2,
    st_err        = 3'h3,
    st_done       = 3'h4,
    st_soft_reset = 3'h5
  } rx_state_e;

endpackage

//--- rtl/strobe_if.sv
`timescale 1ns/1ns
`include "rx_align_params.svh"

interface strobe_if;

  logic                         detect_en;   // Strobe search allowed
  logic                         soft_reset;  // One-cycle clear of sticky flags
  logic [`RXA_NUM_CHANNELS-1:0] stb_det;     // Registered strobe hit
  logic [`RXA_NUM_CHANNELS-1:0] first_stb;   // Sticky, set one cycle after first hit
  logic [`RXA_NUM_CHANNELS-1:0] fifo_wr;     // Sticky FIFO push

  modport decode (
    output stb_det,
    output first_stb,
    output fifo_wr,
    input  detect_en,
    input  soft_reset
  );

  modport exec (
    output detect_en,
    output soft_reset,
    input  first_stb,
    input  fifo_wr
  );

  modport result (
    input stb_det,
    input first_stb,
    input soft_reset
  );

endinterface

//--- rtl/strobe_decode.sv
`timescale 1ns/1ns
`include "rx_align_params.svh"

module strobe_decode (
  input  logic                                              com_clk,
  input  logic                                              rst_com_n,
  input  rx_align_pkg::chan_word_u [`RXA_NUM_CHANNELS-1:0] rx_din,
  input  logic [`RXA_WD_SEL_BITS-1:0]                       rx_stb_wd_sel,
  input  logic [`RXA_WORD_BITS-1:0]                         rx_stb_bit_sel,
  strobe_if.decode                                          stb,
  output logic                                              rx_stb_pos_err,
  output logic                                              rx_stb_pos_coding_err
);

  localparam int NCH = `RXA_NUM_CHANNELS;

  logic [$clog2(`RXA_WD_SEL_BITS)-1:0] wd_idx;   // Lowest selected word
  logic [$clog2(`RXA_WORD_BITS)-1:0]   bit_idx;  // Highest selected bit
  logic [8:0]                          stb_pos;  // Up to 7*40+39
  logic [`RXA_WORD_BITS-1:0]           sel_word [NCH];
  logic [NCH-1:0]                      d_stb_det;

  ////////////////////////////////////////////////////////////
  // Strobe select decode
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    wd_idx = '0;
    for (int w = `RXA_WD_SEL_BITS-1; w >= 0; w--)
      if (rx_stb_wd_sel[w])
        wd_idx = ($bits(wd_idx))'(w);
  end

  always_comb
  begin
    bit_idx = '0;
    for (int b = 0; b < `RXA_WORD_BITS; b++)
      if (rx_stb_bit_sel[b])
        bit_idx = ($bits(bit_idx))'(b);
  end

  // Word past the end of the channel reads zero
  always_comb
  begin
    for (int ch = 0; ch < NCH; ch++)
    begin
      sel_word[ch] = '0;
      for (int w = 0; w < `RXA_WORDS_PER_CHANNEL; w++)
        if ((|rx_stb_wd_sel) && (int'(wd_idx) == w))
          sel_word[ch] = rx_din[ch].word[w];
      d_stb_det[ch] = stb.detect_en & (|(sel_word[ch] & rx_stb_bit_sel));
    end
  end

  ////////////////////////////////////////////////////////////
  // Detection and sticky flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      stb.stb_det   <= '0;
      stb.first_stb <= '0;
      stb.fifo_wr   <= '0;
    end
    else if (stb.soft_reset)
    begin
      stb.stb_det   <= '0;
      stb.first_stb <= '0;
      stb.fifo_wr   <= '0;
    end
    else
    begin
      stb.stb_det   <= d_stb_det;
      stb.first_stb <= stb.first_stb | stb.stb_det;  // Lags fifo_wr by a cycle
      stb.fifo_wr   <= stb.fifo_wr | d_stb_det;
    end
  end

  // Position check
  assign stb_pos = 9'(wd_idx) * 9'd40 + 9'(bit_idx);
  assign rx_stb_pos_err = (stb_pos > 9'(`RXA_BITS_PER_CHANNEL));
  assign rx_stb_pos_coding_err = ($countones(rx_stb_wd_sel) != 1) ||
                                 ($countones(rx_stb_bit_sel) != 1);

  // A channel is never counted aligned before its FIFO starts filling
  a_first_needs_wr : assert property (
    @(posedge com_clk) disable iff (!rst_com_n)
    (stb.first_stb & ~stb.fifo_wr) == '0
  );

endmodule

//--- rtl/align_fifo.sv
`timescale 1ns/1ns
`include "rx_align_params.svh"

module align_fifo (
  input  logic                     com_clk,
  input  logic                     rst_com_n,
  input  logic                     soft_reset,
  input  logic                     push,
  input  logic                     pop,
  input  rx_align_pkg::chan_word_u din,
  output rx_align_pkg::chan_word_u head,
  output logic                     overflow
);

  localparam int AW    = `RXA_FIFO_AD_WIDTH;
  localparam int DEPTH = 1 << AW;

  logic [`RXA_BITS_PER_CHANNEL-1:0] mem [DEPTH];
  logic [AW:0]                      wr_ptr;  // Extra bit for wrap
  logic [AW:0]                      rd_ptr;
  logic                             full;
  logic                             empty;
  logic                             wr_en;
  logic                             rd_en;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign wr_en = push & (~full | pop);  // Pop frees the slot this cycle
  assign rd_en = pop & ~empty;

  always_ff @(posedge com_clk)
  begin
    if (wr_en)
      mem[wr_ptr[AW-1:0]] <= din.flat;
  end

  always_comb
    head.flat = mem[rd_ptr[AW-1:0]];  // Head visible without latency

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end
    else if (soft_reset)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      overflow <= push & full & ~pop;  // Word dropped
    end
  end

  a_no_pop_empty : assert property (
    @(posedge com_clk) disable iff (!rst_com_n)
    pop |-> !empty
  );

endmodule

//--- rtl/align_ctrl.sv
`timescale 1ns/1ns
`include "rx_align_params.svh"

module align_ctrl (
  input  logic                                              com_clk,
  input  logic                                              rst_com_n,
  input  logic                                              rx_online,
  input  logic                                              align_fly,
  input  logic [`RXA_DLY_BITS-1:0]                          rden_dly,
  input  rx_align_pkg::chan_word_u [`RXA_NUM_CHANNELS-1:0] rx_din,
  input  logic                                              intv_err,
  strobe_if.exec                                            stb,
  output rx_align_pkg::chan_word_u [`RXA_NUM_CHANNELS-1:0] rx_dout,
  output logic                                              align_done,
  output logic                                              align_err
);

  import rx_align_pkg::*;

  localparam int NCH = `RXA_NUM_CHANNELS;

  rx_state_e                 state;
  rx_state_e                 state_nxt;
  logic                      rx_online_q;
  logic [`RXA_DLY_BITS-1:0]  rd_dly;
  logic                      all_first;
  logic                      fifo_pop;
  logic [NCH-1:0]            fifo_ovf;
  chan_word_u [NCH-1:0]      fifo_head;
  logic                      d_align_done;
  logic                      d_align_err;

  ////////////////////////////////////////////////////////////
  // Per-channel FIFOs
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < NCH; ch++)
  begin : g_fifo
    align_fifo u_align_fifo (
      .com_clk    (com_clk),
      .rst_com_n  (rst_com_n),
      .soft_reset (stb.soft_reset),
      .push       (stb.fifo_wr[ch]),
      .pop        (fifo_pop),
      .din        (rx_din[ch]),
      .head       (fifo_head[ch]),
      .overflow   (fifo_ovf[ch])
    );
  end

  assign all_first = &stb.first_stb;
  assign fifo_pop  = all_first & ~(|rd_dly);  // Lockstep read

  ////////////////////////////////////////////////////////////
  // Read delay, output and status registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      rx_online_q <= 1'b0;
      rd_dly      <= '0;
      rx_dout     <= '0;
      align_done  <= 1'b0;
      align_err   <= 1'b0;
    end
    else
    begin
      rx_online_q <= rx_online;
      if (rx_online & ~rx_online_q)
        rd_dly <= rden_dly;  // Load on rising edge
      else if (all_first & (|rd_dly))
        rd_dly <= rd_dly - 1'b1;
      if (fifo_pop)
        rx_dout <= fifo_head;
      align_done <= d_align_done;
      align_err  <= d_align_err;
    end
  end

  ////////////////////////////////////////////////////////////
  // Alignment FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
      state <= st_idle;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt      = state;
    d_align_done   = 1'b0;
    d_align_err    = 1'b0;
    stb.soft_reset = 1'b0;
    case (state)
      st_idle:
        if (rx_online)
          state_nxt = st_online;
      st_online:
        if (|fifo_ovf)
          state_nxt = align_fly ? st_soft_reset : st_err;
        else if (all_first)
          state_nxt = st_aligned;
      st_aligned:
        if (~(|rd_dly))
          state_nxt = st_done;
      st_err:
        if (align_fly)
          state_nxt = st_soft_reset;
        else
          d_align_err = 1'b1;
      st_done:
      begin
        d_align_done = 1'b1;
        d_align_err  = intv_err;
        if (intv_err & align_fly)
          state_nxt = st_soft_reset;  // Recover on the fly
      end
      st_soft_reset:
      begin
        stb.soft_reset = 1'b1;
        state_nxt      = st_online;
      end
      default:
        state_nxt = st_idle;
    endcase
  end

  assign stb.detect_en = (state == st_online) || (state == st_aligned) ||
                         (state == st_done);

endmodule

//--- rtl/strobe_intv_check.sv
`timescale 1ns/1ns
`include "rx_align_params.svh"

module strobe_intv_check (
  input  logic                      com_clk,
  input  logic                      rst_com_n,
  input  logic [`RXA_INTV_BITS-1:0] rx_stb_intv,
  strobe_if.result                  stb,
  output logic                      intv_err
);

  localparam int NCH = `RXA_NUM_CHANNELS;

  logic [`RXA_INTV_BITS-1:0] intv_cnt [NCH];
  logic [NCH-1:0]            ch_err;  // Sticky per channel

  ////////////////////////////////////////////////////////////
  // Interval down-counters
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < NCH; ch++)
  begin : g_intv
    always_ff @(posedge com_clk or negedge rst_com_n)
    begin
      if (!rst_com_n)
      begin
        intv_cnt[ch] <= '0;
        ch_err[ch]   <= 1'b0;
      end
      else if (stb.soft_reset)
      begin
        intv_cnt[ch] <= '0;
        ch_err[ch]   <= 1'b0;
      end
      else if (stb.stb_det[ch])
        intv_cnt[ch] <= rx_stb_intv;  // Strobe seen, restart
      else if (stb.first_stb[ch])
      begin
        if (intv_cnt[ch] == `RXA_INTV_BITS'(1))
        begin
          ch_err[ch]   <= 1'b1;  // Strobe missed
          intv_cnt[ch] <= rx_stb_intv;
        end
        else
          intv_cnt[ch] <= intv_cnt[ch] - 1'b1;
      end
    end
  end

  assign intv_err = |ch_err;

endmodule

//--- rtl/rx_align_top.sv
`timescale 1ns/1ns
`include "rx_align_params.svh"

module rx_align_top (
  input  logic                                              com_clk,
  input  logic                                              rst_com_n,
  input  logic                                              rx_online,
  input  logic                                              align_fly,
  input  logic [`RXA_DLY_BITS-1:0]                          rden_dly,
  input  logic [`RXA_WD_SEL_BITS-1:0]                       rx_stb_wd_sel,
  input  logic [`RXA_WORD_BITS-1:0]                         rx_stb_bit_sel,
  input  logic [`RXA_INTV_BITS-1:0]                         rx_stb_intv,
  input  logic [`RXA_NUM_CHANNELS*`RXA_BITS_PER_CHANNEL-1:0] rx_din,
  output logic [`RXA_NUM_CHANNELS*`RXA_BITS_PER_CHANNEL-1:0] rx_dout,
  output logic                                              align_done,
  output logic                                              align_err,
  output logic                                              rx_stb_pos_err,
  output logic                                              rx_stb_pos_coding_err
);

  logic intv_err;  // Result back to execute

  strobe_if u_strobe_if ();

  // Decode
  strobe_decode u_strobe_decode (
    .com_clk               (com_clk),
    .rst_com_n             (rst_com_n),
    .rx_din                (rx_din),
    .rx_stb_wd_sel         (rx_stb_wd_sel),
    .rx_stb_bit_sel        (rx_stb_bit_sel),
    .stb                   (u_strobe_if.decode),
    .rx_stb_pos_err        (rx_stb_pos_err),
    .rx_stb_pos_coding_err (rx_stb_pos_coding_err)
  );

  // Execute
  align_ctrl u_align_ctrl (
    .com_clk    (com_clk),
    .rst_com_n  (rst_com_n),
    .rx_online  (rx_online),
    .align_fly  (align_fly),
    .rden_dly   (rden_dly),
    .rx_din     (rx_din),
    .intv_err   (intv_err),
    .stb        (u_strobe_if.exec),
    .rx_dout    (rx_dout),
    .align_done (align_done),
    .align_err  (align_err)
  );

  // Result
  strobe_intv_check u_strobe_intv_check (
    .com_clk     (com_clk),
    .rst_com_n   (rst_com_n),
    .rx_stb_intv (rx_stb_intv),
    .stb         (u_strobe_if.result),
    .intv_err    (intv_err)
  );

endmodule

//--- dv/rx_align_checker.sv
`timescale 1ns/1ns
`include "rx_align_params.svh"

module rx_align_checker (
  input  logic                                                com_clk,
  input  logic                                                check_idle,
  input  logic                                                check_row,
  input  logic [7:0]                                          row_idx,
  input  logic                                                exp_pos_err,
  input  logic                                                exp_coding_err,
  input  logic                                                exp_done,
  input  logic                                                exp_err,
  input  logic                                                chk_err,
  input  logic [`RXA_NUM_CHANNELS*`RXA_BITS_PER_CHANNEL-1:0] exp_dout,
  input  logic [`RXA_NUM_CHANNELS*`RXA_BITS_PER_CHANNEL-1:0] rx_dout,
  input  logic                                                align_done,
  input  logic                                                align_err,
  input  logic                                                rx_stb_pos_err,
  input  logic                                                rx_stb_pos_coding_err,
  output int                                                  pass_count,
  output int                                                  fail_count
);

  localparam int CW = `RXA_BITS_PER_CHANNEL;

  int n_pass   = 0;
  int n_fail   = 0;
  int row_errs = 0;  // Idle and final checks of the current row

  assign pass_count = n_pass;
  assign fail_count = n_fail;

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      row_errs++;
    end
  endtask

  task automatic compare_word(input string name, input logic [CW-1:0] exp,
                              input logic [CW-1:0] act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      row_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sampling at the falling edge, outputs settled
  ////////////////////////////////////////////////////////////

  always @(negedge com_clk)
  begin
    if (check_idle)
    begin
      compare_flag("align_done", 1'b0, align_done);
      compare_flag("align_err", 1'b0, align_err);
      compare_word("rx_dout[79:0]", '0, rx_dout[CW-1:0]);
      compare_word("rx_dout[159:80]", '0, rx_dout[2*CW-1:CW]);
    end
    if (check_row)
    begin
      compare_flag("rx_stb_pos_err", exp_pos_err, rx_stb_pos_err);
      compare_flag("rx_stb_pos_coding_err", exp_coding_err, rx_stb_pos_coding_err);
      compare_flag("align_done", exp_done, align_done);
      if (chk_err)
        compare_flag("align_err", exp_err, align_err);
      if (exp_done)
      begin
        compare_word("rx_dout[79:0]", exp_dout[CW-1:0], rx_dout[CW-1:0]);
        compare_word("rx_dout[159:80]", exp_dout[2*CW-1:CW], rx_dout[2*CW-1:CW]);
      end
      if (row_errs == 0)
      begin
        n_pass++;
        $display("row %0d: pass", row_idx);
      end
      else
      begin
        n_fail++;
        $display("row %0d: fail with %0d error(s)", row_idx, row_errs);
      end
      row_errs = 0;
    end
  end

endmodule

//--- dv/tb_rx_align.sv
`timescale 1ns/1ns
`include "rx_align_params.svh"

module tb_rx_align;

  localparam int CW         = `RXA_BITS_PER_CHANNEL;
  localparam int DW         = `RXA_NUM_CHANNELS * `RXA_BITS_PER_CHANNEL;
  localparam int NUM_ROWS   = 8;
  localparam int ROW_CYCLES = 300;             // Sample point within a row
  localparam int TIMEOUT    = NUM_ROWS * 320;
  localparam int STB_BIT    = 79;              // Word 1, bit 39 of a channel
  localparam int GAP_LO     = 96;              // Counter range with strobes left out
  localparam int GAP_HI     = 160;
  localparam int RND_DEPTH  = 512;

  typedef struct packed {
    logic [`RXA_WD_SEL_BITS-1:0] wd_sel;
    logic [`RXA_WORD_BITS-1:0]   bit_sel;
    logic [3:0]                  skew0;
    logic [3:0]                  skew1;
    logic [`RXA_DLY_BITS-1:0]    dly;
    logic [`RXA_INTV_BITS-1:0]   intv;
    logic                        fly;
    logic                        stop;        // Strobes pause after alignment
    logic                        pos_err;
    logic                        coding_err;
    logic                        done;
    logic                        err;
    logic                        chk_err;     // Zero leaves align_err unchecked
  } row_t;

  logic                          com_clk = 1'b0;
  logic                          rst_com_n;
  logic                          rx_online;
  logic                          align_fly;
  logic [`RXA_DLY_BITS-1:0]      rden_dly;
  logic [`RXA_WD_SEL_BITS-1:0]   rx_stb_wd_sel;
  logic [`RXA_WORD_BITS-1:0]     rx_stb_bit_sel;
  logic [`RXA_INTV_BITS-1:0]     rx_stb_intv;
  logic [DW-1:0]                 rx_din;
  logic [DW-1:0]                 rx_dout;
  logic                          align_done;
  logic                          align_err;
  logic                          rx_stb_pos_err;
  logic                          rx_stb_pos_coding_err;

  logic                          check_idle;
  logic                          check_row;
  logic [7:0]                    row_idx;
  logic                          exp_pos_err;
  logic                          exp_coding_err;
  logic                          exp_done;
  logic                          exp_err;
  logic                          chk_err;
  logic [DW-1:0]                 exp_dout;
  int                            pass_count;
  int                            fail_count;

  row_t                          rows [NUM_ROWS];
  int                            n_rows = 0;
  logic [47:0]                   rnd_tab [RND_DEPTH];  // Upper payload per counter value
  integer                        seed;
  int                            cycle_cnt = 0;

  always #10 com_clk = ~com_clk;

  rx_align_top u_rx_align_top (
    .com_clk               (com_clk),
    .rst_com_n             (rst_com_n),
    .rx_online             (rx_online),
    .align_fly             (align_fly),
    .rden_dly              (rden_dly),
    .rx_stb_wd_sel         (rx_stb_wd_sel),
    .rx_stb_bit_sel        (rx_stb_bit_sel),
    .rx_stb_intv           (rx_stb_intv),
    .rx_din                (rx_din),
    .rx_dout               (rx_dout),
    .align_done            (align_done),
    .align_err             (align_err),
    .rx_stb_pos_err        (rx_stb_pos_err),
    .rx_stb_pos_coding_err (rx_stb_pos_coding_err)
  );

  rx_align_checker u_rx_align_checker (
    .com_clk               (com_clk),
    .check_idle            (check_idle),
    .check_row             (check_row),
    .row_idx               (row_idx),
    .exp_pos_err           (exp_pos_err),
    .exp_coding_err        (exp_coding_err),
    .exp_done              (exp_done),
    .exp_err               (exp_err),
    .chk_err               (chk_err),
    .exp_dout              (exp_dout),
    .rx_dout               (rx_dout),
    .align_done            (align_done),
    .align_err             (align_err),
    .rx_stb_pos_err        (rx_stb_pos_err),
    .rx_stb_pos_coding_err (rx_stb_pos_coding_err),
    .pass_count            (pass_count),
    .fail_count            (fail_count)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus table and data generation
  ////////////////////////////////////////////////////////////

  task automatic add_row(input logic [7:0] wd, input logic [39:0] bsel, input int sk0,
                         input int sk1, input int dly, input int intv, input logic fly,
                         input logic stop, input logic pos, input logic cod,
                         input logic done, input logic err, input logic chk);
    rows[n_rows] = {wd, bsel, 4'(sk0), 4'(sk1), 3'(dly), 16'(intv), fly, stop,
                    pos, cod, done, err, chk};
    n_rows++;
  endtask

  // Channel word for one payload counter value
  function automatic logic [CW-1:0] payload_word(input int cnt, input int intv,
                                                 input logic stop);
    logic [CW-1:0] w;
    w        = '0;
    w[15:0]  = 16'(cnt);
    w[63:16] = rnd_tab[cnt % RND_DEPTH];
    if ((cnt % intv == 0) && !(stop && cnt >= GAP_LO && cnt < GAP_HI))
      w[STB_BIT] = 1'b1;
    return w;
  endfunction

  function automatic logic [CW-1:0] chan_word(input int k, input int skew, input int intv,
                                              input logic stop);
    logic [CW-1:0] w;
    int            cnt;
    w   = '0;
    cnt = k + 1 - skew;  // Channel lags by its skew
    if (cnt > 0)
      w = payload_word(cnt, intv, stop);
    return w;
  endfunction

  // Reading starts two cycles after the later channel's strobe plus the read delay,
  // with the word after the strobe at the head; rx_dout follows one cycle behind
  function automatic logic [DW-1:0] expected_dout(input row_t row);
    int skew_max;
    int dly;
    int cnt;
    skew_max = (row.skew0 > row.skew1) ? int'(row.skew0) : int'(row.skew1);
    dly      = (row.fly && row.stop) ? 0 : int'(row.dly);  // Delay used up before recovery
    cnt      = ROW_CYCLES - 1 - skew_max - dly;
    return {payload_word(cnt, int'(row.intv), row.stop),
            payload_word(cnt, int'(row.intv), row.stop)};
  endfunction

  task automatic run_row(input int r);
    row_t row;
    row = rows[r];
    @(posedge com_clk);
    rst_com_n      <= 1'b0;
    rx_online      <= 1'b0;
    rx_din         <= '0;
    rx_stb_wd_sel  <= row.wd_sel;
    rx_stb_bit_sel <= row.bit_sel;
    rden_dly       <= row.dly;
    rx_stb_intv    <= row.intv;
    align_fly      <= row.fly;
    row_idx        <= 8'(r);
    exp_pos_err    <= row.pos_err;
    exp_coding_err <= row.coding_err;
    exp_done       <= row.done;
    exp_err        <= row.err;
    chk_err        <= row.chk_err;
    exp_dout       <= expected_dout(row);
    repeat (3) @(posedge com_clk);
    rst_com_n  <= 1'b1;
    @(posedge com_clk);
    check_idle <= 1'b1;  // Outputs idle before rx_online
    @(posedge com_clk);
    check_idle <= 1'b0;
    for (int k = 0; k <= ROW_CYCLES; k++)
    begin
      rx_online <= 1'b1;
      rx_din    <= {chan_word(k, int'(row.skew1), int'(row.intv), row.stop),
                    chan_word(k, int'(row.skew0), int'(row.intv), row.stop)};
      check_row <= (k == ROW_CYCLES);
      @(posedge com_clk);
    end
    check_row <= 1'b0;
    rx_online <= 1'b0;
    rx_din    <= '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] r_hi;
    logic [31:0] r_lo;
    rst_com_n      = 1'b0;
    rx_online      = 1'b0;
    align_fly      = 1'b0;
    rden_dly       = '0;
    rx_stb_wd_sel  = '0;
    rx_stb_bit_sel = '0;
    rx_stb_intv    = '0;
    rx_din         = '0;
    check_idle     = 1'b0;
    check_row      = 1'b0;
    row_idx        = '0;
    exp_pos_err    = 1'b0;
    exp_coding_err = 1'b0;
    exp_done       = 1'b0;
    exp_err        = 1'b0;
    chk_err        = 1'b0;
    exp_dout       = '0;
    seed           = 32'he49d15d7;
    for (int i = 0; i < RND_DEPTH; i++)
    begin
      r_hi       = $random(seed);
      r_lo       = $random(seed);
      rnd_tab[i] = {r_hi[15:0], r_lo};
    end
    //      wd_sel  bit_sel          sk0 sk1 dly intv fly stp pos cod dn er chk
    add_row(8'h02, 40'h00_0000_0000, 0,  0,  0,  16,  0,  0,  0,  1,  0, 0, 1);
    add_row(8'h02, 40'h80_4000_0000, 0,  3,  1,  16,  0,  0,  0,  1,  1, 0, 1);
    add_row(8'h02, 40'h80_0000_0000, 0,  3,  2,  16,  0,  0,  0,  0,  1, 0, 1);
    add_row(8'h04, 40'h00_0000_0020, 0,  3,  1,  16,  0,  0,  1,  0,  0, 0, 1);
    add_row(8'h02, 40'h80_0000_0000, 0,  10, 1,  16,  0,  0,  0,  0,  0, 1, 1);
    add_row(8'h02, 40'h80_0000_0000, 3,  0,  0,  16,  0,  0,  0,  0,  1, 0, 1);
    add_row(8'h02, 40'h80_0000_0000, 0,  3,  1,  16,  0,  1,  0,  0,  1, 1, 1);
    add_row(8'h02, 40'h80_0000_0000, 0,  3,  1,  16,  1,  1,  0,  0,  1, 0, 0);
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    repeat (2) @(posedge com_clk);
    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count == NUM_ROWS)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Run limit
  always @(posedge com_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT)
    begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule

//--- rx_align.f
+incdir+include
rtl/rx_align_pkg.sv
rtl/strobe_if.sv
rtl/strobe_decode.sv
rtl/align_fifo.sv
rtl/align_ctrl.sv
rtl/strobe_intv_check.sv
rtl/rx_align_top.sv
dv/rx_align_checker.sv
dv/tb_rx_align.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the channel aligner testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rx_align -Mdir "$OBJ" -f rx_align.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_rx_align" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
